// ==== test/controlCases.txt ====
# columns: instr irq pc31 expected, all hex
# expected is the 21-bit control word with pcSrc in the top bits
00221820 0 0 008040
00221821 0 0 008000
00221822 0 0 0080c0
00221823 0 0 008080
00221824 0 0 008c00
00221825 0 0 008f00
00221826 0 0 008b00
00221827 0 0 008880
00021900 0 0 00d000
00021902 0 0 00d080
00021903 0 0 00d180
0022182a 0 0 009ac0
03e00008 0 0 0c0000
0020f809 0 0 0c8008
8c220010 0 0 01a016
ac220010 0 0 002022
3c021234 0 0 01a001
2022ffff 0 0 01a042
24220005 0 0 01a002
302200ff 0 0 01ac00
28220007 0 0 01bac2
2c220007 0 0 01ba82
10220004 0 0 041982
14220004 0 0 041882
18200004 0 0 041e82
1c200004 0 0 041f82
04200004 0 0 041d82
08000100 0 0 080000
0c000100 0 0 0a8008
# user state traps
00221820 1 0 138008
fc220000 1 0 138008
0022183f 0 0 178008
fc220000 0 0 178008
44000000 0 0 178008
# kernel state
8c220010 1 1 01a016
00221820 0 1 008040
0022183f 1 1 000000
fc220000 0 1 000000

// ==== mipsControl.f ====
logic/decodePkg.sv
logic/rFuncDecoder.sv
logic/opDecoder.sv
logic/trapResolver.sv
logic/controlUnit.sv
test/controlUnitSva.sv
test/controlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= mipsControl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out=$$(./$(BUILD_DIR)/$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/controlUnitTb.sv ====
`timescale 1ns/10ps

module controlUnitTb;
    import decodePkg::*;

    logic     clk;
    logic     rstN;
    decodeReq req;
    logic     inValid;
    logic     inReady;
    ctrlWord  ctrl;
    logic     outValid;
    logic     outReady;

    // one entry per vector line
    logic [31:0] caseInstr[$];
    logic        caseIrq[$];
    logic        casePc31[$];
    logic [20:0] caseExp[$];
    logic [20:0] inFlight[$]; // accepted, not yet delivered

    controlUnit u_controlUnit (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .inValid  (inValid),
        .inReady  (inReady),
        .ctrl     (ctrl),
        .outValid (outValid),
        .outReady (outReady)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped on first error");
    endtask

    function automatic string mismatchLine(input string msg);
        return $sformatf("CHECK FAILED at %0d ns: %s", $time, msg);
    endfunction

    function automatic decodeReq toReq(input int i);
        decodeReq r;
        r = {caseInstr[i], caseIrq[i], casePc31[i]};
        return r;
    endfunction

    task automatic loadCases();
        int          fd;
        int          got;
        string       line;
        logic [31:0] instr;
        logic        irq;
        logic        pc31;
        logic [20:0] expWord;
        fd = $fopen("test/controlCases.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open test/controlCases.txt");
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            // comment lines fail the hex scan and are skipped
            if (got > 0 && $sscanf(line, "%h %h %h %h", instr, irq, pc31, expWord) == 4) begin
                caseInstr.push_back(instr);
                caseIrq.push_back(irq);
                casePc31.push_back(pc31);
                caseExp.push_back(expWord);
            end
        end
        $fclose(fd);
        if (caseInstr.size() == 0) begin
            abortRun("no vectors found in test/controlCases.txt");
        end
    endtask

    initial begin
        int          idx;
        int          delivered;
        int          idle;
        bit          justAccepted;
        logic [20:0] lastExp;
        logic [20:0] want;

        void'($urandom(38844));
        rstN     = 1'b0;
        req      = '0;
        inValid  = 1'b0;
        outReady = 1'b0;
        loadCases();

        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        assert (!outValid) else abortRun(mismatchLine("outValid high after reset"));
        assert (ctrl == 21'h0) else abortRun(mismatchLine("ctrl not zero after reset"));

        idx          = 0;
        delivered    = 0;
        idle         = 0;
        justAccepted = 1'b0;
        lastExp      = '0;
        req      <= toReq(0);
        inValid  <= 1'b1;
        outReady <= 1'b1;

        while (delivered < caseInstr.size()) begin
            @(posedge clk);
            idle++;
            if (justAccepted) begin // registered exactly one cycle later
                assert (outValid && ctrl == lastExp)
                    else abortRun(mismatchLine($sformatf(
                        "case %0d not registered one cycle after acceptance", idx - 1)));
                justAccepted = 1'b0;
            end
            if (outValid && outReady) begin
                assert (inFlight.size() > 0)
                    else abortRun(mismatchLine("output transfer without accepted input"));
                want = inFlight.pop_front();
                assert (ctrl == want)
                    else abortRun(mismatchLine($sformatf("case %0d: ctrl %h, expected %h",
                        delivered, ctrl, want)));
                delivered++;
                idle = 0;
            end
            if (inValid && inReady) begin
                lastExp = caseExp[idx];
                inFlight.push_back(caseExp[idx]);
                justAccepted = 1'b1;
                idx++;
                idle = 0;
                if (idx < caseInstr.size()) begin
                    req <= toReq(idx);
                end else begin
                    inValid <= 1'b0;
                end
            end
            outReady <= ($urandom % 4) != 0; // stall roughly one cycle in four
            assert (idle < 200)
                else abortRun($sformatf("timeout: no transfer on either side for %0d cycles",
                    idle));
        end

        // nothing may follow the last result
        @(posedge clk);
        assert (!outValid) else abortRun(mismatchLine("extra output after the last case"));

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== test/controlUnitSva.sv ====
`timescale 1ns/10ps

module controlUnitSva (
    input logic               clk,
    input logic               rstN,
    input logic               inReady,
    input decodePkg::ctrlWord ctrl,
    input logic               outValid,
    input logic               outReady
);

    // output register cleared by the async reset
    resetClear: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high while in reset");

    // held result must not move under back-pressure
    holdStable: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(ctrl))
        else $error("ctrl or outValid changed while stalled");

    readyRule: assert property (@(posedge clk) disable iff (!rstN)
        inReady == (!outValid || outReady))
        else $error("inReady does not follow outValid and outReady");

endmodule

bind controlUnit controlUnitSva u_controlUnitSva (
    .clk      (clk),
    .rstN     (rstN),
    .inReady  (inReady),
    .ctrl     (ctrl),
    .outValid (outValid),
    .outReady (outReady)
);

// ==== logic/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  logic               clk,
    input  logic               rstN,
    input  decodePkg::decodeReq req,
    input  logic               inValid,
    output logic               inReady,
    output decodePkg::ctrlWord ctrl,
    output logic               outValid,
    input  logic               outReady
);
    import decodePkg::*;

    ctrlWord fnCtrl;
    ctrlWord opCtrl;
    ctrlWord nextCtrl;
    logic    fnLegal;
    logic    opLegal;
    logic    isRType;
    logic    accept;

    rFuncDecoder u_rFuncDecoder (
        .instr   (req.instr),
        .fnCtrl  (fnCtrl),
        .fnLegal (fnLegal)
    );

    opDecoder u_opDecoder (
        .instr   (req.instr),
        .opCtrl  (opCtrl),
        .opLegal (opLegal),
        .isRType (isRType)
    );

    trapResolver u_trapResolver (
        .fnCtrl   (fnCtrl),
        .opCtrl   (opCtrl),
        .fnLegal  (fnLegal),
        .opLegal  (opLegal),
        .isRType  (isRType),
        .irq      (req.irq),
        .pc31     (req.pc31),
        .nextCtrl (nextCtrl)
    );

    // slot is free when empty or being drained this cycle
    assign inReady = ~outValid | outReady;
    assign accept  = inValid & inReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            ctrl     <= zeroCtrl;
        end else if (accept) begin
            outValid <= 1'b1;
            ctrl     <= nextCtrl;
        end else if (outReady) begin
            outValid <= 1'b0; // drained, nothing new
        end
    end

endmodule

// ==== logic/trapResolver.sv ====
`timescale 1ns/10ps

module trapResolver (
    input  decodePkg::ctrlWord fnCtrl,
    input  decodePkg::ctrlWord opCtrl,
    input  logic               fnLegal,
    input  logic               opLegal,
    input  logic               isRType,
    input  logic               irq,
    input  logic               pc31,
    output decodePkg::ctrlWord nextCtrl
);
    import decodePkg::*;

    ctrlWord decoded;
    logic    legal;
    logic    userMode;

    // R-type result comes from the funct path
    assign decoded  = isRType ? fnCtrl : opCtrl;
    assign legal    = isRType ? fnLegal : opLegal;
    assign userMode = ~pc31;

    always_comb begin
        if (userMode && irq) begin
            nextCtrl = irqCtrl; // interrupt wins over any instruction
        end else if (userMode && !legal) begin
            nextCtrl = excCtrl;
        end else if (!legal) begin
            nextCtrl = zeroCtrl; // kernel state does not trap
        end else begin
            nextCtrl = decoded;
        end
    end

endmodule

// ==== logic/opDecoder.sv ====
`timescale 1ns/10ps

module opDecoder (
    input  decodePkg::instrWord instr,
    output decodePkg::ctrlWord  opCtrl,
    output logic                opLegal,
    output logic                isRType
);
    import decodePkg::*;

    // immediate ALU ops and loads write rt
    function automatic ctrlWord immOp(input logic [aluFunWidth-1:0] fun,
                                      input logic isSigned,
                                      input logic signExt);
        ctrlWord c;
        c          = zeroCtrl;
        c.pcSrc    = pcNext;
        c.regDst   = dstRt;
        c.regWr    = 1'b1;
        c.aluSrc2  = 1'b1;
        c.aluFun   = fun;
        c.sign     = isSigned;
        c.memToReg = wbAlu;
        c.extOp    = signExt;
        return c;
    endfunction

    // conditional branches compare in the ALU, offset is sign-extended
    function automatic ctrlWord branchOp(input logic [aluFunWidth-1:0] fun);
        ctrlWord c;
        c        = zeroCtrl;
        c.pcSrc  = pcBranch;
        c.aluFun = fun;
        c.extOp  = 1'b1;
        return c;
    endfunction

    assign isRType = (instr.iFields.op == opRType);

    always_comb begin
        opCtrl  = zeroCtrl;
        opLegal = 1'b1;
        case (instr.iFields.op)
            opRType: begin
                opCtrl = zeroCtrl; // funct decoder owns this group
            end
            opLw: begin
                opCtrl          = immOp(aluAdd, 1'b0, 1'b1);
                opCtrl.memRd    = 1'b1;
                opCtrl.memToReg = wbMem;
            end
            opSw: begin
                opCtrl.pcSrc   = pcNext;
                opCtrl.aluSrc2 = 1'b1; // base + offset
                opCtrl.aluFun  = aluAdd;
                opCtrl.extOp   = 1'b1;
                opCtrl.memWr   = 1'b1;
            end
            opLui: begin
                opCtrl      = immOp(aluAdd, 1'b0, 1'b0);
                opCtrl.luOp = 1'b1;
            end
            opAddi:  opCtrl = immOp(aluAdd, 1'b1, 1'b1);
            opAddiu: opCtrl = immOp(aluAdd, 1'b0, 1'b1);
            opAndi:  opCtrl = immOp(aluAnd, 1'b0, 1'b0); // zero-extended
            opSlti:  opCtrl = immOp(aluLt, 1'b1, 1'b1);
            opSltiu: opCtrl = immOp(aluLt, 1'b0, 1'b1);
            opBeq:   opCtrl = branchOp(aluEq);
            opBne:   opCtrl = branchOp(aluNe);
            opBlez:  opCtrl = branchOp(aluLez);
            opBgtz:  opCtrl = branchOp(aluGtz);
            opBltz:  opCtrl = branchOp(aluLtz);
            opJ: begin
                opCtrl.pcSrc = pcJump;
            end
            opJal: begin
                opCtrl.pcSrc    = pcJump;
                opCtrl.regWr    = 1'b1;
                opCtrl.regDst   = dstRa;
                opCtrl.memToReg = wbLink;
            end
            default: begin
                opLegal = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/rFuncDecoder.sv ====
`timescale 1ns/10ps

module rFuncDecoder (
    input  decodePkg::instrWord instr,
    output decodePkg::ctrlWord  fnCtrl,
    output logic                fnLegal
);
    import decodePkg::*;

    // common shape of every R-type ALU instruction
    function automatic ctrlWord aluOp(input logic [aluFunWidth-1:0] fun,
                                      input logic isSigned,
                                      input logic fromShamt);
        ctrlWord c;
        c          = zeroCtrl;
        c.pcSrc    = pcNext;
        c.regDst   = dstRd;
        c.regWr    = 1'b1;
        c.aluSrc1  = fromShamt;
        c.aluFun   = fun;
        c.sign     = isSigned;
        c.memToReg = wbAlu;
        return c;
    endfunction

    always_comb begin
        fnCtrl  = zeroCtrl;
        fnLegal = 1'b1;
        case (instr.rFields.funct)
            fnAdd:  fnCtrl = aluOp(aluAdd, 1'b1, 1'b0);
            fnAddu: fnCtrl = aluOp(aluAdd, 1'b0, 1'b0);
            fnSub:  fnCtrl = aluOp(aluSub, 1'b1, 1'b0);
            fnSubu: fnCtrl = aluOp(aluSub, 1'b0, 1'b0);
            fnAnd:  fnCtrl = aluOp(aluAnd, 1'b0, 1'b0);
            fnOr:   fnCtrl = aluOp(aluOr, 1'b0, 1'b0);
            fnXor:  fnCtrl = aluOp(aluXor, 1'b0, 1'b0);
            fnNor:  fnCtrl = aluOp(aluNor, 1'b0, 1'b0);
            fnSll:  fnCtrl = aluOp(aluSll, 1'b0, 1'b1); // shamt operand
            fnSrl:  fnCtrl = aluOp(aluSrl, 1'b0, 1'b1);
            fnSra:  fnCtrl = aluOp(aluSra, 1'b0, 1'b1);
            fnSlt:  fnCtrl = aluOp(aluLt, 1'b1, 1'b0);
            fnJr: begin
                fnCtrl.pcSrc = pcReg;
            end
            fnJalr: begin
                fnCtrl.pcSrc    = pcReg;
                fnCtrl.regWr    = 1'b1;
                fnCtrl.regDst   = dstRd;
                fnCtrl.memToReg = wbLink; // return address
            end
            default: begin
                fnLegal = 1'b0; // word stays zero
            end
        endcase
    end

endmodule

// ==== logic/decodePkg.sv ====
package decodePkg;

    // field widths
    localparam int instrWidth  = 32;
    localparam int opWidth     = 6;
    localparam int functWidth  = 6;
    localparam int regWidth    = 5;
    localparam int shamtWidth  = 5;
    localparam int immWidth    = instrWidth - opWidth - 2 * regWidth;
    localparam int aluFunWidth = 6;
    localparam int pcSelWidth  = 3;
    localparam int dstSelWidth = 2;
    localparam int wbSelWidth  = 2;

    // primary opcodes, instr[31:26]
    localparam logic [opWidth-1:0] opRType = 6'b000000;
    localparam logic [opWidth-1:0] opLw    = 6'b100011;
    localparam logic [opWidth-1:0] opSw    = 6'b101011;
    localparam logic [opWidth-1:0] opLui   = 6'b001111;
    localparam logic [opWidth-1:0] opAddi  = 6'b001000;
    localparam logic [opWidth-1:0] opAddiu = 6'b001001;
    localparam logic [opWidth-1:0] opAndi  = 6'b001100;
    localparam logic [opWidth-1:0] opSlti  = 6'b001010;
    localparam logic [opWidth-1:0] opSltiu = 6'b001011;
    localparam logic [opWidth-1:0] opBeq   = 6'b000100;
    localparam logic [opWidth-1:0] opBne   = 6'b000101;
    localparam logic [opWidth-1:0] opBlez  = 6'b000110;
    localparam logic [opWidth-1:0] opBgtz  = 6'b000111;
    localparam logic [opWidth-1:0] opBltz  = 6'b000001;
    localparam logic [opWidth-1:0] opJ     = 6'b000010;
    localparam logic [opWidth-1:0] opJal   = 6'b000011;

    // funct codes of the R-type group, instr[5:0]
    localparam logic [functWidth-1:0] fnAdd  = 6'b100000;
    localparam logic [functWidth-1:0] fnAddu = 6'b100001;
    localparam logic [functWidth-1:0] fnSub  = 6'b100010;
    localparam logic [functWidth-1:0] fnSubu = 6'b100011;
    localparam logic [functWidth-1:0] fnAnd  = 6'b100100;
    localparam logic [functWidth-1:0] fnOr   = 6'b100101;
    localparam logic [functWidth-1:0] fnXor  = 6'b100110;
    localparam logic [functWidth-1:0] fnNor  = 6'b100111;
    localparam logic [functWidth-1:0] fnSll  = 6'b000000;
    localparam logic [functWidth-1:0] fnSrl  = 6'b000010;
    localparam logic [functWidth-1:0] fnSra  = 6'b000011;
    localparam logic [functWidth-1:0] fnSlt  = 6'b101010;
    localparam logic [functWidth-1:0] fnJr   = 6'b001000;
    localparam logic [functWidth-1:0] fnJalr = 6'b001001;

    // ALU function codes
    localparam logic [aluFunWidth-1:0] aluAdd = 6'b000000;
    localparam logic [aluFunWidth-1:0] aluSub = 6'b000001;
    localparam logic [aluFunWidth-1:0] aluAnd = 6'b011000;
    localparam logic [aluFunWidth-1:0] aluOr  = 6'b011110;
    localparam logic [aluFunWidth-1:0] aluXor = 6'b010110;
    localparam logic [aluFunWidth-1:0] aluNor = 6'b010001;
    localparam logic [aluFunWidth-1:0] aluSll = 6'b100000;
    localparam logic [aluFunWidth-1:0] aluSrl = 6'b100001;
    localparam logic [aluFunWidth-1:0] aluSra = 6'b100011;
    localparam logic [aluFunWidth-1:0] aluLt  = 6'b110101;
    localparam logic [aluFunWidth-1:0] aluEq  = 6'b110011;
    localparam logic [aluFunWidth-1:0] aluNe  = 6'b110001;
    localparam logic [aluFunWidth-1:0] aluLez = 6'b111101;
    localparam logic [aluFunWidth-1:0] aluGtz = 6'b111111;
    localparam logic [aluFunWidth-1:0] aluLtz = 6'b111011;

    localparam logic [pcSelWidth-1:0] pcNext   = 3'd0; // pc + 4
    localparam logic [pcSelWidth-1:0] pcBranch = 3'd1;
    localparam logic [pcSelWidth-1:0] pcJump   = 3'd2;
    localparam logic [pcSelWidth-1:0] pcReg    = 3'd3; // target from rs
    localparam logic [pcSelWidth-1:0] pcIrq    = 3'd4;
    localparam logic [pcSelWidth-1:0] pcExc    = 3'd5;

    localparam logic [dstSelWidth-1:0] dstRd = 2'd0;
    localparam logic [dstSelWidth-1:0] dstRt = 2'd1;
    localparam logic [dstSelWidth-1:0] dstRa = 2'd2; // r31 for jal
    localparam logic [dstSelWidth-1:0] dstXp = 2'd3; // r26 holds trap return address

    localparam logic [wbSelWidth-1:0] wbAlu  = 2'd0;
    localparam logic [wbSelWidth-1:0] wbMem  = 2'd1;
    localparam logic [wbSelWidth-1:0] wbLink = 2'd2;

    typedef struct packed {
        logic [opWidth-1:0]    op;
        logic [regWidth-1:0]   rs;
        logic [regWidth-1:0]   rt;
        logic [regWidth-1:0]   rd;
        logic [shamtWidth-1:0] shamt;
        logic [functWidth-1:0] funct;
    } rTypeFields;

    typedef struct packed {
        logic [opWidth-1:0]  op;
        logic [regWidth-1:0] rs;
        logic [regWidth-1:0] rt;
        logic [immWidth-1:0] imm;
    } iTypeFields;

    // same 32 bits, two field layouts
    typedef union packed {
        rTypeFields rFields;
        iTypeFields iFields;
    } instrWord;

    typedef struct packed {
        instrWord instr;
        logic     irq;
        logic     pc31; // high in kernel state
    } decodeReq;

    typedef struct packed {
        logic [pcSelWidth-1:0]  pcSrc;
        logic [dstSelWidth-1:0] regDst;
        logic                   regWr;
        logic                   aluSrc1; // shamt as operand A
        logic                   aluSrc2; // immediate as operand B
        logic [aluFunWidth-1:0] aluFun;
        logic                   sign;
        logic                   memWr;
        logic                   memRd;
        logic [wbSelWidth-1:0]  memToReg;
        logic                   extOp; // sign-extend imm
        logic                   luOp;  // imm to upper half
    } ctrlWord;

    localparam ctrlWord zeroCtrl = '0;
    localparam ctrlWord irqCtrl  = '{pcSrc: pcIrq, regDst: dstXp, regWr: 1'b1,
                                     memToReg: wbLink, default: '0};
    localparam ctrlWord excCtrl  = '{pcSrc: pcExc, regDst: dstXp, regWr: 1'b1,
                                     memToReg: wbLink, default: '0};

endpackage
